// ==== src/fabric_pkg.sv ====
package fabric_pkg;

  // Array geometry
  localparam int NUM_ROWS  = 2;
  localparam int NUM_COLS  = 2;
  localparam int NUM_TILES = NUM_ROWS * NUM_COLS;

  // Logic cell shape
  localparam int LUT_K         = 4;
  localparam int LUTS_PER_CELL = 2;
  localparam int CELL_INPUTS   = LUT_K * LUTS_PER_CELL;

  // Each tile sees eight routing sources and owns two pads
  localparam int NUM_SRC       = 8;
  localparam int PADS_PER_TILE = 2;

  // Outputs of one logic cell, one bit per LUT
  typedef logic [LUTS_PER_CELL-1:0] cell_out_t;

  // LUT inputs of one cell, LUT0 in the low nibble
  typedef logic [CELL_INPUTS-1:0] lut_in_t;

  // Truth table address of a single LUT
  typedef logic [LUT_K-1:0] lut_addr_t;

  // Routing sources seen by one tile
  typedef logic [NUM_SRC-1:0] src_bus_t;

  // Top level pads, tile t owns bits 2t+1 and 2t
  typedef logic [PADS_PER_TILE*NUM_TILES-1:0] pad_bus_t;

  // All cell outputs, tile t in bits 2t+1 and 2t
  typedef logic [LUTS_PER_CELL*NUM_TILES-1:0] fab_out_t;

  // Per column strobes from the loader
  typedef logic [NUM_COLS-1:0] col_vec_t;

endpackage

// ==== src/cfg_pkg.sv ====
package cfg_pkg;

  // One configuration frame per tile
  localparam int FRAME_BITS    = 64;
  localparam int CFG_WORD_BITS = 8;
  localparam int WORD_CNT_BITS = $clog2(CFG_WORD_BITS);

  typedef logic [CFG_WORD_BITS-1:0] cfg_word_t;
  typedef logic [FRAME_BITS-1:0]    frame_t;
  typedef logic [WORD_CNT_BITS-1:0] bit_cnt_t;

  // Frame layout
  localparam int SEL_BITS   = 3;
  localparam int SEL_LSB    = 0;
  localparam int LUT_BITS   = 16;
  localparam int LUT0_LSB   = 24;
  localparam int LUT1_LSB   = 40;
  localparam int REG_EN_LSB = 56;

  typedef logic [SEL_BITS-1:0] src_sel_t;
  typedef logic [LUT_BITS-1:0] lut_table_t;

  // Routing source numbering, two bits per group
  localparam int SRC_PAD   = 0;
  localparam int SRC_WEST  = 2;
  localparam int SRC_SOUTH = 4;
  localparam int SRC_FB    = 6;

  // Host word loader FSM
  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    COMMIT,
    ACK
  } loader_state_t;

endpackage

// ==== src/config_tile.sv ====
`timescale 1ns/1ps

module config_tile import cfg_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   shift_en,
  input  logic   shift_in,
  input  logic   commit,
  output logic   shift_out,
  output frame_t frame
);

  // Shadow register is loaded serially, the active copy steers the tile
  frame_t shadow_q;
  frame_t active_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      shadow_q <= '0;
    end else if (shift_en) begin
      // New bit enters at the LSB and moves up one place per cycle
      shadow_q <= {shadow_q[FRAME_BITS-2:0], shift_in};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      active_q <= '0;
    end else if (commit) begin
      active_q <= shadow_q;
    end
  end

  // MSB feeds the tile above in the same column
  assign shift_out = shadow_q[FRAME_BITS-1];
  assign frame     = active_q;

endmodule

// ==== src/logic_cell.sv ====
`timescale 1ns/1ps

module logic_cell import fabric_pkg::*, cfg_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  frame_t    frame,
  input  lut_in_t   lut_in,
  output cell_out_t out,
  output cell_out_t reg_out
);

  lut_table_t lut_table [LUTS_PER_CELL];
  lut_addr_t  lut_addr  [LUTS_PER_CELL];
  cell_out_t  lut_res;
  cell_out_t  reg_en;
  cell_out_t  res_q;

  // Truth tables from the active frame
  assign lut_table[0] = frame[LUT0_LSB +: LUT_BITS];
  assign lut_table[1] = frame[LUT1_LSB +: LUT_BITS];
  assign reg_en       = frame[REG_EN_LSB +: LUTS_PER_CELL];

  // LUT l reads inputs 4l..4l+3, lowest input is the address LSB
  always_comb begin
    for (int l = 0; l < LUTS_PER_CELL; l++) begin
      lut_addr[l] = lut_in[l*LUT_K +: LUT_K];
      lut_res[l]  = lut_table[l][lut_addr[l]];
    end
  end

  // Registered copy is taken every cycle, also when not selected,
  // since it is the feedback source of the tile
  always_ff @(posedge clk) begin
    if (rst) begin
      res_q <= '0;
    end else begin
      res_q <= lut_res;
    end
  end

  always_comb begin
    for (int l = 0; l < LUTS_PER_CELL; l++) begin
      out[l] = reg_en[l] ? res_q[l] : lut_res[l];
    end
  end

  assign reg_out = res_q;

endmodule

// ==== src/routing_mux.sv ====
`timescale 1ns/1ps

module routing_mux import fabric_pkg::*, cfg_pkg::*; (
  input  frame_t   frame,
  input  src_bus_t src,
  output lut_in_t  lut_in
);

  // One 3-bit select field per LUT input, packed from the frame LSB
  src_sel_t sel [CELL_INPUTS];

  always_comb begin
    for (int k = 0; k < CELL_INPUTS; k++) begin
      sel[k] = frame[SEL_LSB + k*SEL_BITS +: SEL_BITS];
    end
  end

  // Unidirectional crossbar, any source may drive any LUT input
  always_comb begin
    for (int k = 0; k < CELL_INPUTS; k++) begin
      lut_in[k] = src[sel[k]];
    end
  end

endmodule

// ==== src/config_loader.sv ====
`timescale 1ns/1ps

module config_loader import fabric_pkg::*, cfg_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      cfg_req,
  input  logic      cfg_col,
  input  logic      cfg_commit,
  input  cfg_word_t cfg_word,
  output logic      cfg_ack,
  output col_vec_t  shift_en,
  output col_vec_t  shift_bit,
  output col_vec_t  commit
);

  loader_state_t state_q;
  bit_cnt_t      bit_cnt_q;
  cfg_word_t     word_q;
  logic          col_q;
  logic          ack_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= IDLE;
      bit_cnt_q <= '0;
      ack_q     <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (cfg_req) begin
            bit_cnt_q <= '0;
            state_q   <= cfg_commit ? COMMIT : SHIFT;
          end
        end
        SHIFT: begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
          if (bit_cnt_q == bit_cnt_t'(CFG_WORD_BITS - 1)) begin
            state_q <= ACK;
          end
        end
        // Single cycle commit strobe
        COMMIT: state_q <= ACK;
        ACK: begin
          // Raise ack on entry, then hold it until the host drops req
          if (!ack_q) begin
            ack_q <= 1'b1;
          end else if (!cfg_req) begin
            ack_q   <= 1'b0;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Word and column are captured on the request and shifted out MSB first
  always_ff @(posedge clk) begin
    if (state_q == IDLE && cfg_req) begin
      word_q <= cfg_word;
      col_q  <= cfg_col;
    end else if (state_q == SHIFT) begin
      word_q <= {word_q[CFG_WORD_BITS-2:0], 1'b0};
    end
  end

  always_comb begin
    shift_en  = '0;
    shift_bit = '0;
    commit    = '0;
    shift_en[col_q]  = (state_q == SHIFT);
    shift_bit[col_q] = (state_q == SHIFT) & word_q[CFG_WORD_BITS-1];
    commit[col_q]    = (state_q == COMMIT);
  end

  assign cfg_ack = ack_q;

endmodule

// ==== src/fabric_tiles.sv ====
`timescale 1ns/1ps

module fabric_tiles import fabric_pkg::*, cfg_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  pad_bus_t  pad_in,
  output fab_out_t  fab_out,
  input  logic      cfg_req,
  input  logic      cfg_col,
  input  logic      cfg_commit,
  input  cfg_word_t cfg_word,
  output logic      cfg_ack
);

  //   row 1   (1,0) (1,1)
  //   row 0   (0,0) (0,1)
  // Tile index is row * NUM_COLS + col, chains enter at row 0

  col_vec_t col_shift_en;
  col_vec_t col_shift_bit;
  col_vec_t col_commit;

  frame_t    tile_frame     [NUM_TILES];
  logic      tile_shift_in  [NUM_TILES];
  logic      tile_shift_out [NUM_TILES];
  src_bus_t  tile_src       [NUM_TILES];
  lut_in_t   tile_lut_in    [NUM_TILES];
  cell_out_t tile_out       [NUM_TILES];
  cell_out_t tile_reg_out   [NUM_TILES];

  config_loader u_loader (
    .clk        (clk),
    .rst        (rst),
    .cfg_req    (cfg_req),
    .cfg_col    (cfg_col),
    .cfg_commit (cfg_commit),
    .cfg_word   (cfg_word),
    .cfg_ack    (cfg_ack),
    .shift_en   (col_shift_en),
    .shift_bit  (col_shift_bit),
    .commit     (col_commit)
  );

  for (genvar r = 0; r < NUM_ROWS; r++) begin : g_row
    for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
      localparam int IDX = r * NUM_COLS + c;

      // Configuration chain, row 0 is fed by the loader
      if (r == 0) begin : g_chain_head
        assign tile_shift_in[IDX] = col_shift_bit[c];
      end else begin : g_chain_link
        assign tile_shift_in[IDX] = tile_shift_out[IDX-NUM_COLS];
      end

      // Own pads and registered feedback
      assign tile_src[IDX][SRC_PAD +: PADS_PER_TILE] =
        pad_in[IDX*PADS_PER_TILE +: PADS_PER_TILE];
      assign tile_src[IDX][SRC_FB +: LUTS_PER_CELL] = tile_reg_out[IDX];

      // West neighbor, tied low on the west edge
      if (c > 0) begin : g_west
        assign tile_src[IDX][SRC_WEST +: LUTS_PER_CELL] = tile_out[IDX-1];
      end else begin : g_west_edge
        assign tile_src[IDX][SRC_WEST +: LUTS_PER_CELL] = '0;
      end

      // South neighbor, tied low on the south edge
      if (r > 0) begin : g_south
        assign tile_src[IDX][SRC_SOUTH +: LUTS_PER_CELL] = tile_out[IDX-NUM_COLS];
      end else begin : g_south_edge
        assign tile_src[IDX][SRC_SOUTH +: LUTS_PER_CELL] = '0;
      end

      config_tile u_cfg (
        .clk       (clk),
        .rst       (rst),
        .shift_en  (col_shift_en[c]),
        .shift_in  (tile_shift_in[IDX]),
        .commit    (col_commit[c]),
        .shift_out (tile_shift_out[IDX]),
        .frame     (tile_frame[IDX])
      );

      routing_mux u_mux (
        .frame  (tile_frame[IDX]),
        .src    (tile_src[IDX]),
        .lut_in (tile_lut_in[IDX])
      );

      logic_cell u_cell (
        .clk     (clk),
        .rst     (rst),
        .frame   (tile_frame[IDX]),
        .lut_in  (tile_lut_in[IDX]),
        .out     (tile_out[IDX]),
        .reg_out (tile_reg_out[IDX])
      );

      assign fab_out[IDX*LUTS_PER_CELL +: LUTS_PER_CELL] = tile_out[IDX];
    end
  end

endmodule

// ==== tests/fabric_assert.sv ====
`timescale 1ns/1ps

module fabric_assert import fabric_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     cfg_req,
  input logic     cfg_ack,
  input col_vec_t shift_en,
  input col_vec_t commit
);

  // Count of failed assertions
  int assert_errors = 0;

  // Ack only rises on a pending request
  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(cfg_ack) |-> cfg_req)
    else begin
      $error("cfg_ack rose without cfg_req");
      assert_errors++;
    end

  // Once req has fallen, ack drops at the next edge
  ack_release: assert property (@(posedge clk) disable iff (rst)
    (cfg_ack && !cfg_req) |=> !cfg_ack)
    else begin
      $error("cfg_ack stayed high after cfg_req fell");
      assert_errors++;
    end

  one_column: assert property (@(posedge clk) disable iff (rst)
    $onehot0({shift_en, commit}))
    else begin
      $error("more than one column strobe active");
      assert_errors++;
    end

  reset_quiet: assert property (@(posedge clk) rst |=> (!cfg_ack && commit == '0))
    else begin
      $error("cfg_ack or commit high after reset");
      assert_errors++;
    end

endmodule

bind config_loader fabric_assert u_assert (
  .clk      (clk),
  .rst      (rst),
  .cfg_req  (cfg_req),
  .cfg_ack  (cfg_ack),
  .shift_en (shift_en),
  .commit   (commit)
);

// ==== tests/tb_fabric_tiles.sv ====
`timescale 1ns/1ps

module tb_fabric_tiles import fabric_pkg::*, cfg_pkg::*; ();

  localparam int CLK_PERIOD    = 8;
  localparam int RST_CYCLES    = 8;
  localparam int SETTLE_CYCLES = 4;
  localparam int ACK_LIMIT     = 20;
  // Negedges from the request edge until ack is seen high
  localparam int SHIFT_LAT     = 11;
  localparam int COMMIT_LAT    = 4;
  localparam int COL_WORDS     = NUM_ROWS * FRAME_BITS / CFG_WORD_BITS + 1;
  localparam int TOTAL_WORDS   = 2 + 3 * NUM_COLS * COL_WORDS + COL_WORDS;
  localparam int PAD_CYCLES    = 32 * 3 + 16 * 2 + 4 * SETTLE_CYCLES + 8;

  logic      clk = 1'b0;
  logic      rst;
  pad_bus_t  pad_in;
  fab_out_t  fab_out;
  logic      cfg_req;
  logic      cfg_col;
  logic      cfg_commit;
  cfg_word_t cfg_word;
  logic      cfg_ack;

  // Committed frames as the model sees them, and frames waiting to be loaded
  frame_t      m_frame   [NUM_TILES];
  frame_t      new_frame [NUM_TILES];
  fab_out_t    m_reg;
  logic [31:0] lcg_state = 32'hd1e2;
  int          errors = 0;
  int          checks = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  fabric_tiles DUT (
    .clk        (clk),
    .rst        (rst),
    .pad_in     (pad_in),
    .fab_out    (fab_out),
    .cfg_req    (cfg_req),
    .cfg_col    (cfg_col),
    .cfg_commit (cfg_commit),
    .cfg_word   (cfg_word),
    .cfg_ack    (cfg_ack)
  );

  // Two LCG steps, upper halves only
  function automatic logic [31:0] lcg_next();
    logic [15:0] hi;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    hi = lcg_state[31:16];
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {hi, lcg_state[31:16]};
  endfunction

  // Nibble k of pattern names the source of LUT input k
  function automatic frame_t make_frame(input logic [31:0] pattern, input lut_table_t t0,
                                        input lut_table_t t1, input logic [1:0] en);
    frame_t f;
    f = '0;
    for (int k = 0; k < 8; k++) begin
      f[SEL_LSB + 3*k +: 3] = pattern[4*k +: 3];
    end
    f[LUT0_LSB +: 16] = t0;
    f[LUT1_LSB +: 16] = t1;
    f[REG_EN_LSB +: 2] = en;
    return f;
  endfunction

  // Reference fabric, tiles in index order so west and south are known first
  // Gives the cell outputs, or with want_res the values the cell registers take next
  function automatic fab_out_t model_eval(input pad_bus_t pads, input bit want_res);
    frame_t     f;
    src_bus_t   src;
    lut_in_t    li;
    logic [1:0] west;
    logic [1:0] south;
    logic [1:0] lut_r;
    fab_out_t   o;
    fab_out_t   r;
    o = '0;
    r = '0;
    for (int t = 0; t < NUM_TILES; t++) begin
      f = m_frame[t];
      west  = (t % NUM_COLS != 0) ? o[2*(t-1) +: 2] : 2'b00;
      south = (t >= NUM_COLS) ? o[2*(t-NUM_COLS) +: 2] : 2'b00;
      src = {m_reg[2*t +: 2], south, west, pads[2*t +: 2]};
      for (int k = 0; k < 8; k++) begin
        li[k] = src[f[SEL_LSB + 3*k +: 3]];
      end
      lut_r[0] = f[LUT0_LSB + li[3:0]];
      lut_r[1] = f[LUT1_LSB + li[7:4]];
      o[2*t]   = f[REG_EN_LSB] ? m_reg[2*t] : lut_r[0];
      o[2*t+1] = f[REG_EN_LSB+1] ? m_reg[2*t+1] : lut_r[1];
      r[2*t +: 2] = lut_r;
    end
    return want_res ? r : o;
  endfunction

  // Model cell registers track the DUT edge by edge
  always @(posedge clk) begin
    if (rst) begin
      m_reg <= '0;
    end else begin
      m_reg <= model_eval(pad_in, 1'b1);
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    $display("%s finished with %0d errors", name, errors - err0);
  endtask

  task automatic wait_ack(input logic level, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (cfg_ack !== level && cycles < ACK_LIMIT);
    if (cfg_ack !== level) begin
      $display("cfg_ack did not go to %0b within %0d cycles", level, ACK_LIMIT);
      errors++;
    end
  endtask

  task automatic send_word(input logic col, input logic commit_w, input cfg_word_t word,
                           output int rise, output int fall);
    @(posedge clk);
    cfg_col    <= col;
    cfg_commit <= commit_w;
    cfg_word   <= word;
    cfg_req    <= 1'b1;
    wait_ack(1'b1, rise);
    @(posedge clk);
    cfg_req <= 1'b0;
    wait_ack(1'b0, fall);
  endtask

  task automatic commit_column(input int col);
    int rise;
    int fall;
    send_word(col[0], 1'b1, '0, rise, fall);
    for (int row = 0; row < NUM_ROWS; row++) begin
      m_frame[row*NUM_COLS + col] = new_frame[row*NUM_COLS + col];
    end
  endtask

  // Row 1 frame goes first so that it ends up past row 0 in the chain
  task automatic load_column(input int col, input bit do_commit);
    int rise;
    int fall;
    for (int row = NUM_ROWS - 1; row >= 0; row--) begin
      for (int w = 7; w >= 0; w--) begin
        send_word(col[0], 1'b0, new_frame[row*NUM_COLS + col][8*w +: 8], rise, fall);
      end
    end
    if (do_commit) begin
      commit_column(col);
    end
  endtask

  task automatic random_frames(input logic [31:0] mask, input logic [1:0] en);
    logic [31:0] sel;
    logic [31:0] tab;
    for (int t = 0; t < NUM_TILES; t++) begin
      sel = lcg_next() & mask;
      tab = lcg_next();
      new_frame[t] = make_frame(sel, tab[15:0], tab[31:16], en);
    end
  endtask

  task automatic check_pads(input int n);
    fab_out_t exp;
    repeat (n) begin
      @(posedge clk);
      pad_in <= pad_bus_t'(lcg_next());
      @(negedge clk);
      exp = model_eval(pad_in, 1'b0);
      check_value("fab_out", fab_out, exp);
    end
  endtask

  task automatic program_and_check(input int n);
    load_column(0, 1'b1);
    load_column(1, 1'b1);
    repeat (SETTLE_CYCLES) @(posedge clk);
    check_pads(n);
  endtask

  task automatic test_reset();
    int err0;
    err0 = errors;
    @(negedge clk);
    check_value("fab_out", fab_out, '0);
    check_value("cfg_ack", cfg_ack, '0);
    report_test("reset", err0);
  endtask

  task automatic test_handshake();
    int err0;
    int rise;
    int fall;
    err0 = errors;
    check_value("cfg_ack", cfg_ack, '0);
    send_word(1'b1, 1'b0, 8'ha5, rise, fall);
    check_value("shift ack latency", rise, SHIFT_LAT);
    check_value("cfg_ack held after req fall", fall >= 2, 1);
    send_word(1'b1, 1'b1, 8'h00, rise, fall);
    check_value("commit ack latency", rise, COMMIT_LAT);
    check_value("cfg_ack held after req fall", fall >= 2, 1);
    // Tile (0,1) now holds the word in its select bits only
    m_frame[1] = frame_t'(8'ha5);
    report_test("handshake", err0);
  endtask

  task automatic test_neighbor();
    int          err0;
    logic [31:0] tab;
    err0 = errors;
    for (int t = 0; t < NUM_TILES; t++) begin
      tab = lcg_next();
      // LUT0 reads west and south, tile (1,1) uses neighbors on both LUTs
      new_frame[t] = make_frame((t == 3) ? 32'h3254_5432 : 32'h1010_5432,
                                tab[15:0], tab[31:16], (t == 0) ? 2'b10 : 2'b00);
    end
    program_and_check(32);
    report_test("neighbor routing", err0);
  endtask

  task automatic test_shadow();
    int err0;
    err0 = errors;
    random_frames(32'h1111_1111, 2'b01);
    load_column(0, 1'b0);
    check_pads(16);
    commit_column(0);
    repeat (SETTLE_CYCLES) @(posedge clk);
    check_pads(16);
    report_test("shadow isolation", err0);
  endtask

  initial begin
    int err0;
    int total;
    rst        = 1'b1;
    pad_in     = '0;
    cfg_req    = 1'b0;
    cfg_col    = 1'b0;
    cfg_commit = 1'b0;
    cfg_word   = '0;
    for (int t = 0; t < NUM_TILES; t++) begin
      m_frame[t]   = '0;
      new_frame[t] = '0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_handshake();
    err0 = errors;
    random_frames(32'h1111_1111, 2'b00);
    program_and_check(32);
    report_test("combinational pads", err0);
    err0 = errors;
    random_frames(32'h1111_1111, 2'b11);
    program_and_check(32);
    report_test("registered outputs", err0);
    test_neighbor();
    test_shadow();
    total = errors + DUT.u_loader.u_assert.assert_errors;
    $display("checks: %0d, errors: %0d", checks, total);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (RST_CYCLES + 4 * TOTAL_WORDS * 12 + PAD_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish in the expected number of cycles");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== list.f ====
src/fabric_pkg.sv
src/cfg_pkg.sv
src/config_tile.sv
src/logic_cell.sv
src/routing_mux.sv
src/config_loader.sv
src/fabric_tiles.sv
tests/fabric_assert.sv
tests/tb_fabric_tiles.sv

// ==== Bender.yml ====
package:
  name: fabric_tiles

sources:
  - src/fabric_pkg.sv
  - src/cfg_pkg.sv
  - src/config_tile.sv
  - src/logic_cell.sv
  - src/routing_mux.sv
  - src/config_loader.sv
  - src/fabric_tiles.sv
  - target: test
    files:
      - tests/fabric_assert.sv
      - tests/tb_fabric_tiles.sv
